/* include/mem_consts.svh */
// Width and count constants for the memory-side channels, PMP and arbiter.
// Include this header wherever one of these sizes is needed.
`ifndef MEM_CONSTS_SVH
`define MEM_CONSTS_SVH

// Bus widths
`define ADDR_W 32
`define DATA_W 32
`define BE_W 4

// PMP region count and the width of a region index
`define NUM_REGIONS 4
`define REGION_IDX_W 2

// Order queue depth, one entry per channel
// Must stay a power of two so the queue pointers wrap naturally
`define MAX_OUTST 2

`endif

/* logic/pmp_pkg.sv */
// Types for physical memory protection: privilege, access kind and the
// per-region configuration. Import where regions are stored or checked.
`include "mem_consts.svh"

package pmp_pkg;

  typedef enum logic {
    PRIV_U = 1'b0,
    PRIV_M = 1'b1
  } priv_e;

  // Only top-of-range matching is supported
  typedef enum logic {
    MODE_OFF = 1'b0,
    MODE_TOR = 1'b1
  } region_mode_e;

  typedef enum logic [1:0] {
    ACC_READ  = 2'd0,
    ACC_WRITE = 2'd1,
    ACC_EXEC  = 2'd2
  } pmp_acc_e;

  // One region, bounded below by the previous region's top
  typedef struct packed {
    logic               r;
    logic               w;
    logic               x;
    logic               lock;
    region_mode_e       mode;
    logic [`ADDR_W-1:0] top;
  } pmp_cfg_t;

endpackage

/* logic/mem_bus_pkg.sv */
// Request and response types of the fetch and data channels and of the
// shared memory bus. Import where the channel or bus payloads are handled.
`include "mem_consts.svh"

package mem_bus_pkg;

  // Instruction fetch request
  typedef struct packed {
    logic [`ADDR_W-1:0] addr;
    pmp_pkg::priv_e     priv;
  } instr_req_t;

  // Load/store request
  typedef struct packed {
    logic [`ADDR_W-1:0] addr;
    logic               we;
    logic [`BE_W-1:0]   be;
    logic [`DATA_W-1:0] wdata;
    pmp_pkg::priv_e     priv;
  } data_req_t;

  // Shared memory request, privilege already checked
  typedef struct packed {
    logic [`ADDR_W-1:0] addr;
    logic               we;
    logic [`BE_W-1:0]   be;
    logic [`DATA_W-1:0] wdata;
  } bus_req_t;

  // Response of a channel or of the memory
  typedef struct packed {
    logic [`DATA_W-1:0] rdata;
    logic               err;
  } rsp_t;

endpackage

/* logic/pmp_checker.sv */
// PMP region registers with a small write port in place of a CSR file.
// Checks the fetch and data requests combinationally and flags denials.
`timescale 1ns/1ps
`include "mem_consts.svh"

module pmp_checker (
  input  logic                      clk,
  input  logic                      rst_ni,

  // Region configuration write port
  input  logic                      pmp_cfg_we_i,
  input  logic [`REGION_IDX_W-1:0]  pmp_cfg_idx_i,
  input  pmp_pkg::pmp_cfg_t         pmp_cfg_i,

  // Requests under check
  input  mem_bus_pkg::instr_req_t   instr_req_i,
  input  mem_bus_pkg::data_req_t    data_req_i,

  output logic                      instr_deny_o,
  output logic                      data_deny_o
);

  import pmp_pkg::*;

  pmp_cfg_t cfg_q [`NUM_REGIONS];
  pmp_acc_e data_acc;

  //////////////////////////////////////////////////
  // Region registers
  //////////////////////////////////////////////////

  // Locked regions ignore writes until reset
  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < `NUM_REGIONS; i++) begin
        cfg_q[i] <= '{r: 1'b0, w: 1'b0, x: 1'b0, lock: 1'b0, mode: MODE_OFF, top: '0};
      end
    end else if (pmp_cfg_we_i && !cfg_q[pmp_cfg_idx_i].lock) begin
      cfg_q[pmp_cfg_idx_i] <= pmp_cfg_i;
    end
  end

  //////////////////////////////////////////////////
  // Access decision
  //////////////////////////////////////////////////

  // Lowest matching region decides
  function automatic logic check_deny(input logic [`ADDR_W-1:0] addr,
                                      input priv_e              priv,
                                      input pmp_acc_e           acc);
    logic               matched;
    logic               allow;
    logic               perm;
    logic [`ADDR_W-1:0] base;
    matched = 1'b0;
    // No match: machine mode passes, user mode fails
    allow   = (priv == PRIV_M);
    base    = '0;
    for (int i = 0; i < `NUM_REGIONS; i++) begin
      if (!matched && cfg_q[i].mode == MODE_TOR &&
          addr >= base && addr < cfg_q[i].top) begin
        matched = 1'b1;
        case (acc)
          ACC_EXEC:  perm = cfg_q[i].x;
          ACC_WRITE: perm = cfg_q[i].w;
          default:   perm = cfg_q[i].r;
        endcase
        // Machine mode is only held to the permissions of a locked region
        allow = perm | ((priv == PRIV_M) & ~cfg_q[i].lock);
      end
      base = cfg_q[i].top;
    end
    return ~allow;
  endfunction

  assign data_acc = data_req_i.we ? ACC_WRITE : ACC_READ;

  always_comb begin
    instr_deny_o = check_deny(instr_req_i.addr, instr_req_i.priv, ACC_EXEC);
    data_deny_o  = check_deny(data_req_i.addr, data_req_i.priv, data_acc);
  end

endmodule

/* logic/req_port.sv */
// Channel front end shared by the fetch and data sides. Keeps one request
// in flight, answers PMP-denied requests locally with an error and merges
// that answer with the bus responses.
`timescale 1ns/1ps

module req_port #(
  parameter type payload_t = logic
) (
  input  logic              clk,
  input  logic              rst_ni,

  // Channel side
  input  logic              req_i,
  input  payload_t          payload_i,
  output logic              gnt_o,
  output logic              rvalid_o,
  output mem_bus_pkg::rsp_t rsp_o,

  // PMP decision for the current payload
  input  logic              deny_i,

  // Arbiter side
  output logic              arb_req_o,
  output payload_t          arb_payload_o,
  input  logic              arb_gnt_i,
  input  logic              arb_rvalid_i,
  input  mem_bus_pkg::rsp_t arb_rsp_i
);

  import mem_bus_pkg::*;

  localparam rsp_t ERR_RSP = '{rdata: '0, err: 1'b1};

  logic busy_q;
  logic err_pend_q;
  logic accept;
  logic deny_accept;

  // Nothing new goes out while a response is still owed
  assign arb_req_o     = req_i & ~deny_i & ~busy_q;
  assign arb_payload_o = payload_i;

  // Denied requests are taken at once without touching the bus
  assign gnt_o       = req_i & ~busy_q & (deny_i | arb_gnt_i);
  assign accept      = req_i & gnt_o;
  assign deny_accept = accept & deny_i;

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q     <= 1'b0;
      err_pend_q <= 1'b0;
    end else begin
      err_pend_q <= deny_accept;
      if (rvalid_o) begin
        busy_q <= 1'b0;
      end else if (accept) begin
        busy_q <= 1'b1;
      end
    end
  end

  // Local error and bus response never coincide, one request per channel
  assign rvalid_o = err_pend_q | arb_rvalid_i;
  assign rsp_o    = err_pend_q ? ERR_RSP : arb_rsp_i;

endmodule

/* logic/bus_arbiter.sv */
// Round-robin arbiter between the fetch and data channels onto one memory
// bus. Remembers the grant order and routes each in-order bus response
// back to the channel that issued it.
`timescale 1ns/1ps
`include "mem_consts.svh"

module bus_arbiter (
  input  logic                    clk,
  input  logic                    rst_ni,

  // Fetch channel
  input  logic                    instr_req_i,
  input  mem_bus_pkg::instr_req_t instr_payload_i,
  output logic                    instr_gnt_o,
  output logic                    instr_rvalid_o,
  output mem_bus_pkg::rsp_t       instr_rsp_o,

  // Data channel
  input  logic                    data_req_i,
  input  mem_bus_pkg::data_req_t  data_payload_i,
  output logic                    data_gnt_o,
  output logic                    data_rvalid_o,
  output mem_bus_pkg::rsp_t       data_rsp_o,

  // Shared memory bus
  output logic                    mem_req_o,
  output mem_bus_pkg::bus_req_t   mem_bus_o,
  input  logic                    mem_gnt_i,
  input  logic                    mem_rvalid_i,
  input  mem_bus_pkg::rsp_t       mem_rsp_i
);

  import mem_bus_pkg::*;

  localparam int unsigned PTR_W = $clog2(`MAX_OUTST);

  logic             last_data_q;
  logic             lock_q;
  logic             sel_q;
  logic             rr_data;
  logic             sel_data;
  logic             mem_accept;
  bus_req_t         instr_bus;
  bus_req_t         data_bus;

  // Order queue, one bit per entry, set for a data access
  logic             order_q [`MAX_OUTST];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [PTR_W:0]   order_cnt_q;
  logic             head_data;

  //////////////////////////////////////////////////
  // Channel selection
  //////////////////////////////////////////////////

  // On a conflict the channel not granted last wins
  assign rr_data  = data_req_i & (~instr_req_i | ~last_data_q);
  // Choice is frozen while the memory holds off its grant
  assign sel_data = lock_q ? sel_q : rr_data;

  assign mem_req_o   = instr_req_i | data_req_i;
  assign mem_accept  = mem_req_o & mem_gnt_i;
  assign instr_gnt_o = mem_gnt_i & instr_req_i & ~sel_data;
  assign data_gnt_o  = mem_gnt_i & data_req_i & sel_data;

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      last_data_q <= 1'b0;
      lock_q      <= 1'b0;
      sel_q       <= 1'b0;
    end else if (mem_accept) begin
      last_data_q <= sel_data;
      lock_q      <= 1'b0;
    end else if (mem_req_o) begin
      lock_q      <= 1'b1;
      sel_q       <= sel_data;
    end
  end

  // Fetches go out as full-word reads
  assign instr_bus = '{addr: instr_payload_i.addr, we: 1'b0, be: '1, wdata: '0};
  assign data_bus  = '{addr:  data_payload_i.addr,
                       we:    data_payload_i.we,
                       be:    data_payload_i.be,
                       wdata: data_payload_i.wdata};

  assign mem_bus_o = sel_data ? data_bus : instr_bus;

  //////////////////////////////////////////////////
  // Response order tracking
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (mem_accept) begin
      order_q[wr_ptr_q] <= sel_data;
    end
  end

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q    <= '0;
      rd_ptr_q    <= '0;
      order_cnt_q <= '0;
    end else begin
      if (mem_accept) begin
        wr_ptr_q <= wr_ptr_q + PTR_W'(1);
      end
      if (mem_rvalid_i) begin
        rd_ptr_q <= rd_ptr_q + PTR_W'(1);
      end
      // Push and pop may land in the same cycle
      order_cnt_q <= order_cnt_q + (PTR_W+1)'(mem_accept) - (PTR_W+1)'(mem_rvalid_i);
    end
  end

  // Oldest grant owns the response
  assign head_data      = order_q[rd_ptr_q];
  assign instr_rvalid_o = mem_rvalid_i & ~head_data;
  assign data_rvalid_o  = mem_rvalid_i & head_data;
  assign instr_rsp_o    = mem_rsp_i;
  assign data_rsp_o     = mem_rsp_i;

endmodule

/* logic/mem_top.sv */
// Memory-side top level: fetch and data channels, each checked by the PMP,
// sharing one memory bus through the arbiter.
`timescale 1ns/1ps
`include "mem_consts.svh"

module mem_top (
  input  logic                      clk,
  input  logic                      rst_ni,

  // Fetch channel
  input  logic                      instr_req_i,
  input  mem_bus_pkg::instr_req_t   instr_req_pl_i,
  output logic                      instr_gnt_o,
  output logic                      instr_rvalid_o,
  output mem_bus_pkg::rsp_t         instr_rsp_o,

  // Data channel
  input  logic                      data_req_i,
  input  mem_bus_pkg::data_req_t    data_req_pl_i,
  output logic                      data_gnt_o,
  output logic                      data_rvalid_o,
  output mem_bus_pkg::rsp_t         data_rsp_o,

  // PMP configuration
  input  logic                      pmp_cfg_we_i,
  input  logic [`REGION_IDX_W-1:0]  pmp_cfg_idx_i,
  input  pmp_pkg::pmp_cfg_t         pmp_cfg_i,

  // Memory bus
  output logic                      mem_req_o,
  output mem_bus_pkg::bus_req_t     mem_bus_o,
  input  logic                      mem_gnt_i,
  input  logic                      mem_rvalid_i,
  input  mem_bus_pkg::rsp_t         mem_rsp_i
);

  import mem_bus_pkg::*;

  logic       instr_deny;
  logic       data_deny;

  // Channel front ends to arbiter
  logic       instr_arb_req;
  instr_req_t instr_arb_pl;
  logic       instr_arb_gnt;
  logic       instr_arb_rvalid;
  rsp_t       instr_arb_rsp;
  logic       data_arb_req;
  data_req_t  data_arb_pl;
  logic       data_arb_gnt;
  logic       data_arb_rvalid;
  rsp_t       data_arb_rsp;

  pmp_checker u_pmp_checker (
    .clk           (clk),
    .rst_ni        (rst_ni),
    .pmp_cfg_we_i  (pmp_cfg_we_i),
    .pmp_cfg_idx_i (pmp_cfg_idx_i),
    .pmp_cfg_i     (pmp_cfg_i),
    .instr_req_i   (instr_req_pl_i),
    .data_req_i    (data_req_pl_i),
    .instr_deny_o  (instr_deny),
    .data_deny_o   (data_deny)
  );

  req_port #(
    .payload_t (instr_req_t)
  ) u_instr_port (
    .clk           (clk),
    .rst_ni        (rst_ni),
    .req_i         (instr_req_i),
    .payload_i     (instr_req_pl_i),
    .gnt_o         (instr_gnt_o),
    .rvalid_o      (instr_rvalid_o),
    .rsp_o         (instr_rsp_o),
    .deny_i        (instr_deny),
    .arb_req_o     (instr_arb_req),
    .arb_payload_o (instr_arb_pl),
    .arb_gnt_i     (instr_arb_gnt),
    .arb_rvalid_i  (instr_arb_rvalid),
    .arb_rsp_i     (instr_arb_rsp)
  );

  req_port #(
    .payload_t (data_req_t)
  ) u_data_port (
    .clk           (clk),
    .rst_ni        (rst_ni),
    .req_i         (data_req_i),
    .payload_i     (data_req_pl_i),
    .gnt_o         (data_gnt_o),
    .rvalid_o      (data_rvalid_o),
    .rsp_o         (data_rsp_o),
    .deny_i        (data_deny),
    .arb_req_o     (data_arb_req),
    .arb_payload_o (data_arb_pl),
    .arb_gnt_i     (data_arb_gnt),
    .arb_rvalid_i  (data_arb_rvalid),
    .arb_rsp_i     (data_arb_rsp)
  );

  bus_arbiter u_bus_arbiter (
    .clk             (clk),
    .rst_ni          (rst_ni),
    .instr_req_i     (instr_arb_req),
    .instr_payload_i (instr_arb_pl),
    .instr_gnt_o     (instr_arb_gnt),
    .instr_rvalid_o  (instr_arb_rvalid),
    .instr_rsp_o     (instr_arb_rsp),
    .data_req_i      (data_arb_req),
    .data_payload_i  (data_arb_pl),
    .data_gnt_o      (data_arb_gnt),
    .data_rvalid_o   (data_arb_rvalid),
    .data_rsp_o      (data_arb_rsp),
    .mem_req_o       (mem_req_o),
    .mem_bus_o       (mem_bus_o),
    .mem_gnt_i       (mem_gnt_i),
    .mem_rvalid_i    (mem_rvalid_i),
    .mem_rsp_i       (mem_rsp_i)
  );

endmodule

/* testbench/tb_clk_gen.sv */
// Clock and reset source for the testbench. Gives an 8 ns clock and holds
// the active-low reset for the first two clock cycles.
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int unsigned HALF_NS    = 4,
  parameter int unsigned RST_CYCLES = 2
) (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #(HALF_NS) clk_o = ~clk_o;
  end

  // Release on a falling edge, away from the sampling edge
  initial begin
    rst_n_o = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;
  end

endmodule

/* testbench/mem_top_props.sv */
// Protocol assertions for the shared memory bus, bound into bus_arbiter.
// Covers request stability under back-pressure and response ownership.
`timescale 1ns/1ps
`include "mem_consts.svh"

module mem_top_props (
  input logic                          clk,
  input logic                          rst_ni,
  input logic                          mem_req_o,
  input mem_bus_pkg::bus_req_t         mem_bus_o,
  input logic                          mem_gnt_i,
  input logic                          mem_rvalid_i,
  input logic [$clog2(`MAX_OUTST):0]   order_cnt_q
);

  int unsigned fail_cnt = 0;

  // A pending request holds its payload until the memory takes it
  req_stable: assert property (@(posedge clk) disable iff (!rst_ni)
      mem_req_o && !mem_gnt_i |=> mem_req_o && $stable(mem_bus_o))
    else begin
      fail_cnt++;
      $error("memory request changed or dropped before its grant");
    end

  // Every bus response needs a recorded grant
  rsp_owned: assert property (@(posedge clk) disable iff (!rst_ni)
      mem_rvalid_i |-> order_cnt_q != '0)
    else begin
      fail_cnt++;
      $error("memory response with an empty order queue");
    end

endmodule

bind bus_arbiter mem_top_props u_props (
  .clk          (clk),
  .rst_ni       (rst_ni),
  .mem_req_o    (mem_req_o),
  .mem_bus_o    (mem_bus_o),
  .mem_gnt_i    (mem_gnt_i),
  .mem_rvalid_i (mem_rvalid_i),
  .order_cnt_q  (order_cnt_q)
);

/* testbench/tb_mem_top.sv */
// Testbench for mem_top: drives both channels and the PMP write port, models
// the memory with random grant delay and latency, and checks every channel
// response against a reference model of memory and protection.
`timescale 1ns/1ps
`include "mem_consts.svh"

module tb_mem_top;

  import mem_bus_pkg::*;
  import pmp_pkg::*;

  localparam int unsigned NUM_TXN   = 140;
  localparam int unsigned WORST_CYC = 24;
  localparam int unsigned CLK_NS    = 8;

  logic clk;
  logic rst_ni;

  // DUT inputs
  logic                     instr_req = 1'b0;
  instr_req_t               instr_pl = '0;
  logic                     data_req = 1'b0;
  data_req_t                data_pl = '0;
  logic                     pmp_cfg_we = 1'b0;
  logic [`REGION_IDX_W-1:0] pmp_cfg_idx = '0;
  pmp_cfg_t                 pmp_cfg = '0;
  logic                     mem_gnt = 1'b0;
  logic                     mem_rvalid = 1'b0;
  rsp_t                     mem_rsp = '0;

  // DUT outputs
  logic     instr_gnt;
  logic     instr_rvalid;
  rsp_t     instr_rsp;
  logic     data_gnt;
  logic     data_rvalid;
  rsp_t     data_rsp;
  logic     mem_req;
  bus_req_t mem_bus;

  // Memory model and reference state
  logic [`DATA_W-1:0] mem_words [1024];
  logic [`DATA_W-1:0] shadow_words [1024];
  pmp_cfg_t           shadow_cfg [`NUM_REGIONS];
  int unsigned        rsp_due_q [$];
  logic [`DATA_W-1:0] rsp_data_q [$];
  rsp_t               exp_instr_q [$];
  rsp_t               exp_data_q [$];
  logic [1:0]         gnt_wait = 2'd0;
  int unsigned        cyc = 0;
  int unsigned        bus_cnt = 0;
  int unsigned        exp_bus_cnt = 0;
  integer             seed = 32'hf2a3;

  tb_clk_gen u_clk_gen (
    .clk_o   (clk),
    .rst_n_o (rst_ni)
  );

  mem_top u_mem_top (
    .clk            (clk),
    .rst_ni         (rst_ni),
    .instr_req_i    (instr_req),
    .instr_req_pl_i (instr_pl),
    .instr_gnt_o    (instr_gnt),
    .instr_rvalid_o (instr_rvalid),
    .instr_rsp_o    (instr_rsp),
    .data_req_i     (data_req),
    .data_req_pl_i  (data_pl),
    .data_gnt_o     (data_gnt),
    .data_rvalid_o  (data_rvalid),
    .data_rsp_o     (data_rsp),
    .pmp_cfg_we_i   (pmp_cfg_we),
    .pmp_cfg_idx_i  (pmp_cfg_idx),
    .pmp_cfg_i      (pmp_cfg),
    .mem_req_o      (mem_req),
    .mem_bus_o      (mem_bus),
    .mem_gnt_i      (mem_gnt),
    .mem_rvalid_i   (mem_rvalid),
    .mem_rsp_i      (mem_rsp)
  );

  //////////////////////////////////////////////////
  // Failure reporting
  //////////////////////////////////////////////////

  task automatic abort_run();
    $display("Done: errors found");
    $fatal(1);
  endtask

  task automatic report_failure(input string msg);
    $display("%s", msg);
    abort_run();
  endtask

  task automatic compare(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("ERR %0t ns %s: got %08h, expected %08h", $time, what, got, exp);
      abort_run();
    end
  endtask

  task automatic check_rsp(input string ch, input rsp_t got, input rsp_t want);
    compare({ch, " rdata"}, got.rdata, want.rdata);
    compare({ch, " err"}, 32'(got.err), 32'(want.err));
  endtask

  //////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////

  function automatic logic [31:0] fill_word(input int unsigned i);
    return (i * 32'h0001_0003) ^ 32'hc3a5_5a3c;
  endfunction

  function automatic logic [31:0] merge_word(input logic [31:0] old,
                                             input logic [31:0] wdata,
                                             input logic [3:0]  be);
    logic [31:0] mask;
    mask = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
    return (wdata & mask) | (old & ~mask);
  endfunction

  // TOR regions, lowest match wins, unmatched is machine only
  function automatic logic pmp_allows(input logic [31:0] addr, input priv_e priv,
                                      input pmp_acc_e acc);
    logic [31:0] lo;
    logic        found;
    logic        perm;
    logic        allow;
    lo    = '0;
    found = 1'b0;
    allow = (priv == PRIV_M);
    for (int i = 0; i < `NUM_REGIONS; i++) begin
      if (!found && shadow_cfg[i].mode == MODE_TOR && addr >= lo && addr < shadow_cfg[i].top) begin
        found = 1'b1;
        perm  = (acc == ACC_EXEC)  ? shadow_cfg[i].x :
                (acc == ACC_WRITE) ? shadow_cfg[i].w : shadow_cfg[i].r;
        allow = (priv == PRIV_M && !shadow_cfg[i].lock) ? 1'b1 : perm;
      end
      lo = shadow_cfg[i].top;
    end
    return allow;
  endfunction

  function automatic rsp_t expect_fetch(input logic [31:0] addr, input priv_e priv);
    if (!pmp_allows(addr, priv, ACC_EXEC)) begin
      return '{rdata: '0, err: 1'b1};
    end
    exp_bus_cnt++;
    return '{rdata: shadow_words[addr[11:2]], err: 1'b0};
  endfunction

  function automatic rsp_t expect_data(input logic [31:0] addr, input logic we,
                                       input logic [3:0] be, input logic [31:0] wdata,
                                       input priv_e priv);
    if (!pmp_allows(addr, priv, we ? ACC_WRITE : ACC_READ)) begin
      return '{rdata: '0, err: 1'b1};
    end
    exp_bus_cnt++;
    if (we) begin
      shadow_words[addr[11:2]] = merge_word(shadow_words[addr[11:2]], wdata, be);
      return '{rdata: '0, err: 1'b0};
    end
    return '{rdata: shadow_words[addr[11:2]], err: 1'b0};
  endfunction

  //////////////////////////////////////////////////
  // Memory model
  //////////////////////////////////////////////////

  always @(negedge clk) begin
    mem_gnt = (gnt_wait == 2'd0);
    if (rsp_due_q.size() != 0 && rsp_due_q[0] <= cyc) begin
      mem_rvalid = 1'b1;
      mem_rsp    = '{rdata: rsp_data_q[0], err: 1'b0};
    end else begin
      mem_rvalid = 1'b0;
      mem_rsp    = '0;
    end
  end

  always @(posedge clk) begin : mem_side
    logic [31:0] r;
    logic [9:0]  idx;
    if (mem_rvalid) begin
      void'(rsp_due_q.pop_front());
      void'(rsp_data_q.pop_front());
    end
    if (mem_req && mem_gnt) begin
      r   = $random(seed);
      idx = mem_bus.addr[11:2];
      bus_cnt++;
      if (mem_bus.we) begin
        for (int b = 0; b < 4; b++) begin
          if (mem_bus.be[b]) mem_words[idx][8*b +: 8] = mem_bus.wdata[8*b +: 8];
        end
        rsp_data_q.push_back('0);
      end else begin
        rsp_data_q.push_back(mem_words[idx]);
      end
      // Latency 1 to 4 cycles, next grant held off 0 to 3 cycles
      rsp_due_q.push_back(cyc + 32'(r[1:0]) + 32'd1);
      gnt_wait = r[5:4];
    end else if (gnt_wait != 2'd0) begin
      gnt_wait = gnt_wait - 2'd1;
    end
    cyc++;
  end

  //////////////////////////////////////////////////
  // Response checker
  //////////////////////////////////////////////////

  always @(posedge clk) begin : rsp_check
    rsp_t want;
    if (rst_ni && instr_rvalid) begin
      if (exp_instr_q.size() == 0) begin
        report_failure("Fetch response arrived with no fetch outstanding");
      end else begin
        want = exp_instr_q.pop_front();
        check_rsp("fetch", instr_rsp, want);
      end
    end
    if (rst_ni && data_rvalid) begin
      if (exp_data_q.size() == 0) begin
        report_failure("Data response arrived with no access outstanding");
      end else begin
        want = exp_data_q.pop_front();
        check_rsp("data", data_rsp, want);
      end
    end
  end

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////

  task automatic cfg_write(input logic [1:0] idx, input pmp_cfg_t cfg);
    @(negedge clk);
    pmp_cfg_we  = 1'b1;
    pmp_cfg_idx = idx;
    pmp_cfg     = cfg;
    @(negedge clk);
    pmp_cfg_we = 1'b0;
    if (!shadow_cfg[idx].lock) shadow_cfg[idx] = cfg;
  endtask

  task automatic fetch(input logic [31:0] addr, input priv_e priv);
    @(negedge clk);
    instr_req = 1'b1;
    instr_pl  = '{addr: addr, priv: priv};
    @(posedge clk);
    while (!instr_gnt) @(posedge clk);
    exp_instr_q.push_back(expect_fetch(addr, priv));
    @(negedge clk);
    instr_req = 1'b0;
  endtask

  task automatic data_access(input logic [31:0] addr, input logic we, input logic [3:0] be,
                             input logic [31:0] wdata, input priv_e priv);
    @(negedge clk);
    data_req = 1'b1;
    data_pl  = '{addr: addr, we: we, be: be, wdata: wdata, priv: priv};
    @(posedge clk);
    while (!data_gnt) @(posedge clk);
    exp_data_q.push_back(expect_data(addr, we, be, wdata, priv));
    @(negedge clk);
    data_req = 1'b0;
  endtask

  task automatic random_fetches(input int n);
    logic [31:0] r;
    for (int i = 0; i < n; i++) begin
      r = $random(seed);
      fetch({20'h0, r[11:2], 2'b00}, priv_e'(r[12]));
    end
  endtask

  task automatic random_data(input int n);
    logic [31:0] r;
    logic [31:0] w;
    for (int i = 0; i < n; i++) begin
      r = $random(seed);
      w = $random(seed);
      data_access({20'h0, r[11:2], 2'b00}, r[13], r[17:14], w, priv_e'(r[12]));
    end
  endtask

  task automatic wait_idle();
    while (exp_instr_q.size() != 0 || exp_data_q.size() != 0) @(posedge clk);
    @(posedge clk);
  endtask

  initial begin
    logic [31:0] r;
    logic [31:0] w;
    for (int i = 0; i < 1024; i++) begin
      mem_words[i]    = fill_word(i);
      shadow_words[i] = fill_word(i);
    end
    for (int i = 0; i < `NUM_REGIONS; i++) shadow_cfg[i] = '0;
    wait (rst_ni == 1'b1);

    // Reset state with no traffic
    repeat (3) begin
      @(posedge clk);
      compare("idle outputs after reset",
              32'({instr_gnt, instr_rvalid, data_gnt, data_rvalid, mem_req}), 32'h0);
    end

    // Fetch from region 0
    cfg_write(2'd0, '{r: 1'b1, w: 1'b1, x: 1'b1, lock: 1'b0, mode: MODE_TOR, top: 32'h400});
    for (int i = 0; i < 12; i++) fetch(i * 84, PRIV_U);
    wait_idle();

    // Stores with random byte enables, then loads back
    for (int i = 0; i < 16; i++) begin
      r = $random(seed);
      w = $random(seed);
      data_access(i * 36, 1'b1, r[3:0], w, PRIV_U);
    end
    for (int i = 0; i < 16; i++) data_access(i * 36, 1'b0, 4'h0, '0, PRIV_U);
    wait_idle();

    // Protection: region 1 read only, region 2 locked execute only
    cfg_write(2'd1, '{r: 1'b1, w: 1'b0, x: 1'b0, lock: 1'b0, mode: MODE_TOR, top: 32'h600});
    cfg_write(2'd2, '{r: 1'b0, w: 1'b0, x: 1'b1, lock: 1'b1, mode: MODE_TOR, top: 32'h800});
    data_access(32'h900, 1'b0, 4'hf, '0, PRIV_U);
    data_access(32'h500, 1'b1, 4'hf, 32'h1234_5678, PRIV_U);
    fetch(32'h500, PRIV_U);
    data_access(32'h520, 1'b0, 4'hf, '0, PRIV_U);
    data_access(32'h700, 1'b0, 4'hf, '0, PRIV_M);
    data_access(32'h704, 1'b1, 4'hf, 32'hdead_beef, PRIV_M);
    data_access(32'h504, 1'b1, 4'h3, 32'hcafe_f00d, PRIV_M);
    data_access(32'h900, 1'b0, 4'hf, '0, PRIV_M);
    // Locked region ignores this rewrite
    cfg_write(2'd2, '{r: 1'b1, w: 1'b1, x: 1'b1, lock: 1'b0, mode: MODE_TOR, top: 32'h800});
    data_access(32'h700, 1'b0, 4'hf, '0, PRIV_M);
    fetch(32'h700, PRIV_U);
    wait_idle();
    compare("memory bus request count", bus_cnt, exp_bus_cnt);

    // Both channels at once under grant back-pressure
    fork
      random_fetches(40);
      random_data(40);
    join
    wait_idle();
    compare("memory bus request count", bus_cnt, exp_bus_cnt);

    if (u_mem_top.u_bus_arbiter.u_props.fail_cnt == 0) begin
      $display("Done: no errors");
      $finish;
    end else begin
      report_failure("A memory bus protocol assertion failed during the run");
    end
  end

  // Watchdog sized from the transaction count
  initial begin
    #(NUM_TXN * WORST_CYC * CLK_NS);
    report_failure("Watchdog expired before the tests completed");
  end

endmodule

/* mem_top.f */
+incdir+include
logic/pmp_pkg.sv
logic/mem_bus_pkg.sv
logic/pmp_checker.sv
logic/req_port.sv
logic/bus_arbiter.sv
logic/mem_top.sv
testbench/tb_clk_gen.sv
testbench/mem_top_props.sv
testbench/tb_mem_top.sv

/* Makefile */
# Verilator build and run of the mem_top testbench

.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run the testbench, check the log"
	@echo "make clean  remove the build directory and the log"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert -j 0 --top-module tb_mem_top -f mem_top.f -o sim_mem_top
	./obj_dir/sim_mem_top | tee sim.log
	grep -q "^Done: no errors$$" sim.log

clean:
	rm -rf obj_dir sim.log
